//--- cov3d_gram.sv
`default_nettype none

module cov3d_gram (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          valid_i,
  input  gs_pkg::mat3_t m_i,
  output logic          valid_o,
  output gs_pkg::cov3_t cov_o
);

  import gs_pkg::*;

  // column pairs of the upper triangle, order xx xy xz yy yz zz
  localparam int unsigned COL_A [6] = '{0, 0, 0, 1, 1, 2};
  localparam int unsigned COL_B [6] = '{0, 1, 2, 1, 2, 2};

  logic [1:0] vld_sr;

  fxp_t       prod_q [6][3];  // entry e, row i
  fxp_t       ent    [6];

  // ---------------------------------------------------------------------------
  // valid pipe
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[0], valid_i};
    end
  end

  assign valid_o = vld_sr[1];

  // ---------------------------------------------------------------------------
  // stage 1, M[i][j] * M[i][k] for the eighteen needed pairs
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      for (int e = 0; e < 6; e++) begin
        for (int i = 0; i < 3; i++) begin
          prod_q[e][i] <= fxp_mul(vec_at(row_at(m_i, i), COL_A[e]),
                                  vec_at(row_at(m_i, i), COL_B[e]));
        end
      end
    end
  end

  // sum over rows, 16 bit wrap
  always_comb begin
    for (int e = 0; e < 6; e++) begin
      ent[e] = prod_q[e][0] + prod_q[e][1] + prod_q[e][2];
    end
  end

  // stage 2
  always_ff @(posedge clk_i) begin
    if (vld_sr[0]) begin
      cov_o <= '{xx: ent[0],
                 xy: ent[1],
                 xz: ent[2],
                 yy: ent[3],
                 yz: ent[4],
                 zz: ent[5]};
    end
  end

endmodule

`default_nettype wire

//--- gaussian_preprocess.sv
`default_nettype none

module gaussian_preprocess (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  input  gs_pkg::gaussian_t in_gaussian_i,
  output logic              out_valid_o,
  output gs_pkg::splat_t    out_splat_o,
  output logic [15:0]       cull_count_o
);

  import gs_pkg::*;

  // ---------------------------------------------------------------------------
  // branch to join wires
  // ---------------------------------------------------------------------------
  logic  vt_valid;
  vec3_t p_view;
  logic  culled;

  logic  m_valid;
  mat3_t m_mat;     // M = S * R

  cov3_t cov;

  // view branch, three stages
  view_transform u_view_transform (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (in_valid_i),
    .point_i  (in_gaussian_i.point),
    .view_i   (in_gaussian_i.view),
    .valid_o  (vt_valid),
    .p_view_o (p_view),
    .culled_o (culled)
  );

  // covariance branch, one stage plus two stages
  scale_rotate u_scale_rotate (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (in_valid_i),
    .scale_i    (in_gaussian_i.scale),
    .modifier_i (in_gaussian_i.modifier),
    .rotation_i (in_gaussian_i.rotation),
    .valid_o    (m_valid),
    .m_o        (m_mat)
  );

  // its strobe has the same timing as vt_valid, so the join ignores it
  cov3d_gram u_cov3d_gram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (m_valid),
    .m_i     (m_mat),
    .valid_o (),
    .cov_o   (cov)
  );

  splat_emit u_splat_emit (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .vt_valid_i   (vt_valid),
    .p_view_i     (p_view),
    .culled_i     (culled),
    .cov_i        (cov),
    .out_valid_o  (out_valid_o),
    .out_splat_o  (out_splat_o),
    .cull_count_o (cull_count_o)
  );

endmodule

`default_nettype wire

//--- gaussian_preprocess_assertions.sv
`default_nettype none

`include "gs_defs.svh"

module gaussian_preprocess_assertions (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        in_valid_i,
  input logic        out_valid_i,   // the top level's out_valid_o
  input logic [15:0] cull_count_i   // the top level's cull_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // ---------------------------------------------------------------------------
  // output strobe
  // ---------------------------------------------------------------------------
  // quiet output while reset is held
  a_no_out_in_reset : assert property (
    @(posedge clk_i) !rst_n_i |-> !out_valid_i
  ) else $error("out_valid_o high during reset");

  // strobe sampled at edge k shows up as sampled high at edge k + latency
  a_out_after_in : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i |-> $past(in_valid_i, `GS_LATENCY)
  ) else $error("out_valid_o without a matching input strobe");

  // ---------------------------------------------------------------------------
  // cull counter
  // ---------------------------------------------------------------------------
  a_cull_step : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (cull_count_i == $past(cull_count_i)) ||
    (cull_count_i == $past(cull_count_i) + 16'd1)   // wraps at 16 bits
  ) else $error("cull_count_o moved by more than one");

endmodule

`default_nettype wire

//--- gs_defs.svh
`ifndef GS_DEFS_SVH
`define GS_DEFS_SVH

// ---------------------------------------------------------------------------
// fixed point format, signed Q8.8
// ---------------------------------------------------------------------------
`define GS_DATA_W     16
`define GS_FRAC_BITS  8

// near plane depth in Q8.8, roughly 0.2
`define GS_NEAR_Z     16'sh0033

// ---------------------------------------------------------------------------
// pipeline
// ---------------------------------------------------------------------------
// strobe in to strobe out, in clock cycles
`define GS_LATENCY    4

`endif

//--- gs_pkg.sv
`default_nettype none

`include "gs_defs.svh"

package gs_pkg;

  typedef logic signed [`GS_DATA_W-1:0] fxp_t;  // one Q8.8 word

  typedef struct packed {
    fxp_t x;
    fxp_t y;
    fxp_t z;
  } vec3_t;

  // row major, r0 is the top row
  typedef struct packed {
    vec3_t r0;
    vec3_t r1;
    vec3_t r2;
  } mat3_t;

  typedef struct packed {
    mat3_t rot;
    vec3_t trans;
  } view_mat_t;

  typedef struct packed {
    vec3_t     point;     // world space position
    view_mat_t view;
    vec3_t     scale;
    fxp_t      modifier;  // global scale modifier
    mat3_t     rotation;
  } gaussian_t;

  // upper triangle of the symmetric 3d covariance
  typedef struct packed {
    fxp_t xx;
    fxp_t xy;
    fxp_t xz;
    fxp_t yy;
    fxp_t yz;
    fxp_t zz;
  } cov3_t;

  typedef struct packed {
    vec3_t p_view;
    cov3_t cov;
  } splat_t;

  // full signed product, back to Q8.8, low word kept
  function automatic fxp_t fxp_mul(fxp_t a, fxp_t b);
    logic signed [2*`GS_DATA_W-1:0] prod;
    prod = a * b;
    return fxp_t'(prod >>> `GS_FRAC_BITS);
  endfunction

  function automatic fxp_t vec_at(vec3_t v, int unsigned idx);
    case (idx)
      0:       return v.x;
      1:       return v.y;
      default: return v.z;
    endcase
  endfunction

  function automatic vec3_t row_at(mat3_t m, int unsigned idx);
    case (idx)
      0:       return m.r0;
      1:       return m.r1;
      default: return m.r2;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  -f sources.f --top-module tb_gaussian_preprocess -o sim_tb \
  && { ./obj_dir/sim_tb > sim.log 2>&1; cat sim.log; } \
  && ! grep -q "TEST FAILED" sim.log \
  && grep -q "TEST PASSED" sim.log \
  || { echo "simulation did not pass"; exit 1; }

echo "simulation passed"
exit 0

//--- scale_rotate.sv
`default_nettype none

module scale_rotate (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          valid_i,
  input  gs_pkg::vec3_t scale_i,
  input  gs_pkg::fxp_t  modifier_i,
  input  gs_pkg::mat3_t rotation_i,
  output logic          valid_o,
  output gs_pkg::mat3_t m_o
);

  import gs_pkg::*;

  vec3_t eff_scale;  // scale times modifier, per axis
  mat3_t m_d;

  // every element of one rotation row times the same factor
  function automatic vec3_t scale_row(vec3_t r, fxp_t s);
    vec3_t res;
    res.x = fxp_mul(r.x, s);
    res.y = fxp_mul(r.y, s);
    res.z = fxp_mul(r.z, s);
    return res;
  endfunction

  // ---------------------------------------------------------------------------
  // M = S * R, row i of R scaled by effective scale i
  // ---------------------------------------------------------------------------
  always_comb begin
    eff_scale.x = fxp_mul(scale_i.x, modifier_i);
    eff_scale.y = fxp_mul(scale_i.y, modifier_i);
    eff_scale.z = fxp_mul(scale_i.z, modifier_i);

    m_d.r0 = scale_row(rotation_i.r0, eff_scale.x);
    m_d.r1 = scale_row(rotation_i.r1, eff_scale.y);
    m_d.r2 = scale_row(rotation_i.r2, eff_scale.z);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      m_o <= m_d;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
gs_pkg.sv
view_transform.sv
scale_rotate.sv
cov3d_gram.sv
splat_emit.sv
gaussian_preprocess.sv
gaussian_preprocess_assertions.sv
tb_gaussian_preprocess.sv

//--- splat_emit.sv
`default_nettype none

module splat_emit (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           vt_valid_i,   // both branches are aligned on this strobe
  input  gs_pkg::vec3_t  p_view_i,
  input  logic           culled_i,
  input  gs_pkg::cov3_t  cov_i,
  output logic           out_valid_o,
  output gs_pkg::splat_t out_splat_o,
  output logic [15:0]    cull_count_o
);

  logic keep;
  logic drop;

  assign keep = vt_valid_i & ~culled_i;
  assign drop = vt_valid_i & culled_i;

  // ---------------------------------------------------------------------------
  // output strobe and cull counter
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o  <= 1'b0;
      cull_count_o <= '0;
    end else begin
      out_valid_o <= keep;
      if (drop) begin
        cull_count_o <= cull_count_o + 16'd1;  // wraps at 16 bits
      end
    end
  end

  // joined payload, only loaded for a splat that survives
  always_ff @(posedge clk_i) begin
    if (keep) begin
      out_splat_o <= '{p_view: p_view_i, cov: cov_i};
    end
  end

endmodule

`default_nettype wire

//--- tb_gaussian_preprocess.sv
`default_nettype none

`include "gs_defs.svh"

module tb_gaussian_preprocess;

  timeunit 1ns;
  timeprecision 1ps;

  import gs_pkg::*;

  localparam int   N_DIRECTED    = 12;
  localparam int   N_ROWS        = 32;
  localparam int   DRAIN_TIMEOUT = 100;  // cycles
  localparam int   CULL_TIMEOUT  = 20;
  localparam fxp_t ONE           = 16'sh0100;

  // expected splat plus the cycle in which its input strobe is sampled
  typedef struct packed {
    splat_t      splat;
    logic [31:0] stamp;
  } exp_t;

  logic       clk_i;
  logic       rst_n_i;
  logic       in_valid_i;
  gaussian_t  in_gaussian_i;
  logic       out_valid_o;
  splat_t     out_splat_o;
  logic [15:0] cull_count_o;

  // stimulus and expected-value table
  gaussian_t  stim_g    [N_ROWS];
  int         gap       [N_ROWS];  // idle cycles after the row
  splat_t     exp_splat [N_ROWS];
  logic       exp_cull  [N_ROWS];

  exp_t        exp_q [$];
  logic [15:0] exp_culls;
  logic [31:0] lcg_state;
  int          ncyc = 0;            // counts falling edges
  int          value_errors = 0;
  int          other_errors = 0;
  int          n_checked = 0;

  gaussian_preprocess dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .in_gaussian_i (in_gaussian_i),
    .out_valid_o   (out_valid_o),
    .out_splat_o   (out_splat_o),
    .cull_count_o  (cull_count_o)
  );

  bind gaussian_preprocess gaussian_preprocess_assertions u_assertions (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .out_valid_i  (out_valid_o),
    .cull_count_i (cull_count_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ---------------------------------------------------------------------------
  // reference model, Q8.8 with 16 bit wrapping sums
  // ---------------------------------------------------------------------------
  function automatic fxp_t q_mul(fxp_t a, fxp_t b);
    longint p;
    p = longint'(a) * longint'(b);
    p = p >>> `GS_FRAC_BITS;
    return p[15:0];
  endfunction

  function automatic fxp_t comp(vec3_t v, int j);
    return v[(2 - j) * 16 +: 16];  // x sits in the top word
  endfunction

  function automatic fxp_t elem(mat3_t m, int i, int j);
    return m[(8 - 3 * i - j) * 16 +: 16];
  endfunction

  task automatic ref_model(input gaussian_t g, output splat_t s, output logic culled);
    int   ca [6];
    int   cb [6];
    fxp_t pv [3];
    fxp_t es [3];
    fxp_t m  [3][3];
    fxp_t cv [6];
    ca = '{0, 0, 0, 1, 1, 2};
    cb = '{0, 1, 2, 1, 2, 2};
    for (int i = 0; i < 3; i++) begin
      pv[i] = comp(g.view.trans, i);
      for (int j = 0; j < 3; j++) begin
        pv[i] = pv[i] + q_mul(elem(g.view.rot, i, j), comp(g.point, j));
      end
      es[i] = q_mul(comp(g.scale, i), g.modifier);
      for (int j = 0; j < 3; j++) begin
        m[i][j] = q_mul(elem(g.rotation, i, j), es[i]);
      end
    end
    for (int e = 0; e < 6; e++) begin
      cv[e] = '0;
      for (int i = 0; i < 3; i++) begin
        cv[e] = cv[e] + q_mul(m[i][ca[e]], m[i][cb[e]]);
      end
    end
    s.p_view = '{pv[0], pv[1], pv[2]};
    s.cov    = '{cv[0], cv[1], cv[2], cv[3], cv[4], cv[5]};
    culled   = (pv[2] <= `GS_NEAR_Z);  // signed depth
  endtask

  // ---------------------------------------------------------------------------
  // table construction
  // ---------------------------------------------------------------------------
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic vec3_t make_vec(fxp_t x, fxp_t y, fxp_t z);
    return '{x, y, z};
  endfunction

  function automatic mat3_t make_mat(fxp_t a, fxp_t b, fxp_t c, fxp_t d, fxp_t e,
                                     fxp_t f, fxp_t g, fxp_t h, fxp_t k);
    return '{make_vec(a, b, c), make_vec(d, e, f), make_vec(g, h, k)};
  endfunction

  function automatic gaussian_t make_gaussian(vec3_t pt, mat3_t vrot, vec3_t tr,
                                              vec3_t sc, fxp_t md, mat3_t rot);
    gaussian_t g;
    g.point      = pt;
    g.view.rot   = vrot;
    g.view.trans = tr;
    g.scale      = sc;
    g.modifier   = md;
    g.rotation   = rot;
    return g;
  endfunction

  task automatic build_table();
    mat3_t     id;
    mat3_t     rz45;   // about 45 degrees around z
    mat3_t     ry30;   // about 30 degrees around y
    mat3_t     big;
    vec3_t     zero;
    vec3_t     unit;
    gaussian_t g;
    id   = make_mat(ONE, 0, 0, 0, ONE, 0, 0, 0, ONE);
    rz45 = make_mat(16'h00B5, 16'hFF4B, 0, 16'h00B5, 16'h00B5, 0, 0, 0, ONE);
    ry30 = make_mat(16'h00DD, 0, 16'h0080, 0, ONE, 0, 16'hFF80, 0, 16'h00DD);
    big  = make_mat(16'h0400, 0, 0, 0, 16'h0400, 0, 0, 0, ONE);
    zero = make_vec(0, 0, 0);
    unit = make_vec(ONE, ONE, ONE);
    stim_g[0]  = make_gaussian(make_vec(16'h0100, 16'h0200, 16'h0300), id,
                               make_vec(16'h0080, 16'hFF00, 16'h0200),
                               make_vec(16'h0080, 16'h0180, 16'h0200), ONE, id);
    stim_g[1]  = make_gaussian(make_vec(0, 0, 16'h0010), id, zero, unit, ONE, id);
    stim_g[2]  = make_gaussian(make_vec(0, 0, `GS_NEAR_Z), id, zero, unit, ONE, id);
    stim_g[3]  = make_gaussian(make_vec(0, 0, 16'h0034), id, zero, unit, ONE, id);
    stim_g[4]  = make_gaussian(make_vec(0, 0, 16'hFE00), id, zero, unit, ONE, id);
    stim_g[5]  = make_gaussian(make_vec(0, 0, ONE), id, zero,
                               make_vec(16'h0200, 16'h0300, 16'h0040), ONE, id);
    stim_g[6]  = make_gaussian(make_vec(ONE, 16'hFF80, 16'h0400), id, make_vec(0, 0, ONE),
                               make_vec(16'h0180, 16'h0080, 16'h0280), 16'h00C0, rz45);
    stim_g[7]  = make_gaussian(make_vec(16'h7000, 16'h7000, 16'h2000), big,
                               make_vec(16'h7000, 0, 16'h1000),
                               make_vec(16'h1000, 16'h0C00, 16'h0A00), ONE, id);
    stim_g[8]  = make_gaussian(make_vec(16'h0200, ONE, 16'h0180), ry30,
                               make_vec(16'hFF00, 16'h0040, 16'h0300),
                               make_vec(ONE, 16'h0200, 16'h0080), 16'h0140, ry30);
    stim_g[9]  = make_gaussian(make_vec(16'hFF00, 16'hFE80, 16'h0800), id, zero,
                               make_vec(16'h0300, ONE, 16'h0200), 16'h0080, ry30);
    stim_g[10] = make_gaussian(make_vec(0, 0, ONE), id, zero,
                               make_vec(16'hFF00, 16'h0180, 16'hFE00), ONE, id);
    stim_g[11] = make_gaussian(make_vec(0, 0, 16'h0020), id, zero,
                               make_vec(16'hFF00, 16'h0180, 16'hFE00), ONE, id);
    gap = '{1, 0, 0, 0, 2, 1, 0, 1, 2, 0, 0, 1,
            0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    lcg_state = 32'd79041;  // seed
    for (int r = N_DIRECTED; r < N_ROWS; r++) begin
      for (int w = 0; w < 28; w++) begin
        g[w * 16 +: 16] = lcg_next();
      end
      stim_g[r] = g;
      gap[r]    = (lcg_next() % 3 == 0) ? 1 : 0;
    end
    for (int r = 0; r < N_ROWS; r++) begin
      ref_model(stim_g[r], exp_splat[r], exp_cull[r]);
    end
  endtask

  // ---------------------------------------------------------------------------
  // output monitor and scoreboard
  // ---------------------------------------------------------------------------
  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error: %s got 0x%04h expected 0x%04h", name, got, exp);
    end
  endtask

  always @(negedge clk_i) begin
    exp_t e;
    ncyc = ncyc + 1;
    if (rst_n_i && out_valid_o) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("output strobe at cycle %0d with no splat expected", ncyc);
      end else begin
        e = exp_q.pop_front();
        n_checked++;
        if (ncyc != e.stamp + `GS_LATENCY) begin
          other_errors++;
          $display("splat came out at cycle %0d but was due at cycle %0d",
                   ncyc, e.stamp + `GS_LATENCY);
        end
        check_word("p_view.x", out_splat_o.p_view.x, e.splat.p_view.x);
        check_word("p_view.y", out_splat_o.p_view.y, e.splat.p_view.y);
        check_word("p_view.z", out_splat_o.p_view.z, e.splat.p_view.z);
        check_word("cov.xx", out_splat_o.cov.xx, e.splat.cov.xx);
        check_word("cov.xy", out_splat_o.cov.xy, e.splat.cov.xy);
        check_word("cov.xz", out_splat_o.cov.xz, e.splat.cov.xz);
        check_word("cov.yy", out_splat_o.cov.yy, e.splat.cov.yy);
        check_word("cov.yz", out_splat_o.cov.yz, e.splat.cov.yz);
        check_word("cov.zz", out_splat_o.cov.zz, e.splat.cov.zz);
      end
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus and end of run
  // ---------------------------------------------------------------------------
  initial begin
    int waited;
    rst_n_i       = 1'b0;
    in_valid_i    = 1'b0;
    in_gaussian_i = '0;
    exp_culls     = '0;
    build_table();
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_word("out_valid_o", {15'd0, out_valid_o}, 16'h0000);
    check_word("cull_count_o", cull_count_o, 16'h0000);

    for (int r = 0; r < N_ROWS; r++) begin
      @(posedge clk_i);
      in_valid_i    <= 1'b1;
      in_gaussian_i <= stim_g[r];
      if (exp_cull[r]) begin
        exp_culls = exp_culls + 16'd1;
      end else begin
        exp_q.push_back(exp_t'{splat: exp_splat[r], stamp: ncyc + 1});  // sampled next edge
      end
      repeat (gap[r]) begin
        @(posedge clk_i);
        in_valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;

    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("timed out with %0d expected splats still missing", exp_q.size());
    end

    waited = 0;
    while (cull_count_o !== exp_culls && waited < CULL_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    repeat (`GS_LATENCY + 1) @(negedge clk_i);  // no late culls may follow
    check_word("cull_count_o", cull_count_o, exp_culls);

    $display("splats checked %0d, value errors %0d, other errors %0d",
             n_checked, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- view_transform.sv
`default_nettype none

`include "gs_defs.svh"

module view_transform (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  gs_pkg::vec3_t     point_i,
  input  gs_pkg::view_mat_t view_i,
  output logic              valid_o,
  output gs_pkg::vec3_t     p_view_o,
  output logic              culled_o
);

  import gs_pkg::*;

  localparam fxp_t NEAR_Z = `GS_NEAR_Z;

  logic [2:0] vld_sr;        // one bit per stage

  fxp_t       prod_q [3][3]; // rotation row i times point element j
  vec3_t      trans_q;
  vec3_t      p_sum_q;
  logic       cull_d;

  // ---------------------------------------------------------------------------
  // valid pipe
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[1:0], valid_i};
    end
  end

  assign valid_o = vld_sr[2];

  // ---------------------------------------------------------------------------
  // stage 1, nine products
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
          prod_q[i][j] <= fxp_mul(vec_at(row_at(view_i.rot, i), j), vec_at(point_i, j));
        end
      end
      trans_q <= view_i.trans;  // rides along for the add in stage 2
    end
  end

  // stage 2, row sums plus translation, wrapping
  always_ff @(posedge clk_i) begin
    if (vld_sr[0]) begin
      p_sum_q.x <= prod_q[0][0] + prod_q[0][1] + prod_q[0][2] + trans_q.x;
      p_sum_q.y <= prod_q[1][0] + prod_q[1][1] + prod_q[1][2] + trans_q.y;
      p_sum_q.z <= prod_q[2][0] + prod_q[2][1] + prod_q[2][2] + trans_q.z;
    end
  end

  // at or in front of the near plane
  assign cull_d = (p_sum_q.z <= NEAR_Z);

  // stage 3, output register with the cull decision
  always_ff @(posedge clk_i) begin
    if (vld_sr[1]) begin
      p_view_o <= p_sum_q;
      culled_o <= cull_d;
    end
  end

endmodule

`default_nettype wire
